// ==== sim/i2c_config_checker.sv ====
// Scoreboard for the codec configuration block
// Rebuilds the expected write order from the register table and the NACKs the slave gave
// Also watches config_done, config_error and the idle bus
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_settings.svh"

module i2c_config_checker (
	input  logic        CLOCK,
	input  logic        RESET,
	input  logic        start,
	input  wire         scl,
	input  wire         sda,
	input  logic        config_done,
	input  logic        config_error,
	input  logic        force_mode,
	input  logic [3:0]  force_idx,
	input  logic [7:0]  rx_byte,
	input  logic        rx_nack,
	input  logic [15:0] byte_cnt,
	input  logic [15:0] start_cnt,
	input  logic [15:0] stop_cnt,
	output int          errors,
	output int          xfers
);
	import i2c_cfg_pkg::*;

	localparam int LEN = `I2C_TABLE_LEN;

	int          idx;           // Entry expected next
	int          tries;         // Failed attempts at idx
	int          nbytes;        // Bytes in the current frame
	int          forced_frames; // Frames carrying the forced entry's word
	logic        frame_nack;
	logic        exp_err;       // Model's config_error
	logic        err_seen;
	logic        done_q;
	logic        start_q;       // start seen at the last rising edge
	logic [7:0]  exp_byte;
	logic [15:0] frame_pair;    // Sub-address and data as received

	task automatic report_mismatch(input string what);
		$display("FAILED at %0t: %s", $time, what);
		errors = errors + 1;
	endtask

	task automatic clear_model;
		idx           = 0;
		tries         = 0;
		nbytes        = 0;
		forced_frames = 0;
		frame_nack    = 1'b0;
		exp_err       = 1'b0;
		err_seen      = 1'b0;
	endtask

	// Status once the last entry has gone out
	task automatic check_table_end;
		int n;
		n = 0;
		while (config_done !== 1'b1 && n < 64) begin
			@(negedge CLOCK);
			n = n + 1;
		end
		if (config_done !== 1'b1)
			report_mismatch("config_done did not rise after the last entry");
		else if (config_error !== exp_err)
			report_mismatch($sformatf("config_error is %b, expected %b", config_error, exp_err));
		if (force_mode && forced_frames != `I2C_MAX_RETRY)
			report_mismatch($sformatf("entry %0d attempted %0d times, expected %0d",
				force_idx, forced_frames, `I2C_MAX_RETRY));
	endtask

	initial begin
		errors  = 0;
		xfers   = 0;
		done_q  = 1'b0;
		start_q = 1'b0;
		clear_model();
	end

	// Idle bus right after reset
	always @(posedge RESET) begin
		@(negedge CLOCK);
		if (scl !== 1'b1 || sda !== 1'b1 || config_done !== 1'b0)
			report_mismatch("bus not idle or config_done set after reset");
	end

	always @(start_cnt) begin
		if (start_cnt != 0) begin
			nbytes     = 0;
			frame_nack = 1'b0;
			frame_pair = '0;
			if (config_done === 1'b1)
				report_mismatch("start condition while config_done is high");
		end
	end

	// Each byte against the table in frame order
	always @(byte_cnt) begin
		if (byte_cnt != 0) begin
			if (idx >= LEN) begin
				report_mismatch("write after the last table entry");
			end else if (nbytes > 2) begin
				report_mismatch("more than three bytes in one frame");
			end else begin
				case (nbytes)
					0: exp_byte = `I2C_SLAVE_ADDR;
					1: exp_byte = cfg_table[idx][15:8];
					default: exp_byte = cfg_table[idx][7:0];
				endcase
				if (rx_byte !== exp_byte)
					report_mismatch($sformatf("entry %0d byte %0d is %h, expected %h",
						idx, nbytes, rx_byte, exp_byte));
				if (nbytes == 1)
					frame_pair[15:8] = rx_byte;
				if (nbytes == 2)
					frame_pair[7:0] = rx_byte;
			end
			if (rx_nack)
				frame_nack = 1'b1;
			nbytes = nbytes + 1;
		end
	end

	// Retry rule applied at each stop
	always @(stop_cnt) begin
		if (stop_cnt != 0) begin
			xfers = xfers + 1;
			if (nbytes != 3)
				report_mismatch($sformatf("frame ended after %0d bytes", nbytes));
			if (nbytes == 3 && frame_pair == cfg_table[force_idx])
				forced_frames = forced_frames + 1; // Counted from the bus itself
			if (idx < LEN) begin
				if (frame_nack && tries < `I2C_MAX_RETRY - 1) begin
					tries = tries + 1; // Same word again
				end else begin
					if (frame_nack)
						exp_err = 1'b1; // Entry skipped
					idx   = idx + 1;
					tries = 0;
					if (idx == LEN)
						check_table_end();
				end
			end
		end
	end

	always @(posedge CLOCK)
		start_q <= start;

	// Status flags sampled mid-cycle
	always @(negedge CLOCK) begin
		if (RESET === 1'b1) begin
			if (start_q) begin
				if (config_done !== 1'b0 || config_error !== 1'b0)
					report_mismatch("start pulse did not clear config_done and config_error");
				clear_model(); // Table replays from entry 0
			end else begin
				if (config_error === 1'b1 && !exp_err)
					report_mismatch("config_error high with every entry acknowledged");
				if (err_seen && config_error !== 1'b1) begin
					report_mismatch("config_error dropped without a start pulse");
					err_seen = 1'b0;
				end
				if (config_done === 1'b1 && !done_q && idx != LEN)
					report_mismatch($sformatf("config_done rose at entry %0d", idx));
				if (config_done === 1'b1 && (scl !== 1'b1 || sda !== 1'b1))
					report_mismatch("bus active while config_done is high");
			end
			if (config_error === 1'b1)
				err_seen = 1'b1;
			done_q = (config_done === 1'b1);
		end
	end

endmodule

`default_nettype wire

// ==== sim/i2c_slave_model.sv ====
// Two-wire slave model for the codec
// Decodes start, bytes and stop, answers each byte with ACK or a random NACK
// Forced mode NACKs every attempt at one table entry
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_settings.svh"

module i2c_slave_model (
	input  wire         scl,
	inout  wire         sda,
	input  logic        force_mode,
	input  logic [3:0]  force_idx,  // Entry that never gets an ACK
	output logic [7:0]  rx_byte,    // Last byte received
	output logic        rx_nack,    // Answer given to rx_byte
	output logic [15:0] byte_cnt,   // Bumped once per byte
	output logic [15:0] start_cnt,  // Bumped on each start condition
	output logic [15:0] stop_cnt    // Bumped on each stop condition
);
	import i2c_cfg_pkg::*;

	integer     seed;
	integer     roll;
	logic       in_frame;
	logic       acking;     // Inside the acknowledge clock
	logic       drive_low;
	logic       frame_nack; // Any NACK given in this frame
	logic [3:0] bit_cnt;
	logic [1:0] byte_idx;
	logic [7:0] shreg;
	logic [7:0] prev_byte;  // Sub-address, for the forced match
	int         fail_run;   // NACKed frames in a row

	assign sda = drive_low ? 1'b0 : 1'bz; // Open drain

	initial begin
		seed      = 76;
		in_frame  = 1'b0;
		acking    = 1'b0;
		drive_low = 1'b0;
		fail_run  = 0;
		byte_cnt  = '0;
		start_cnt = '0;
		stop_cnt  = '0;
	end

	// Start, SDA falls while SCL is high
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			in_frame   = 1'b1;
			acking     = 1'b0;
			drive_low  = 1'b0;
			bit_cnt    = '0;
			byte_idx   = '0;
			frame_nack = 1'b0;
			start_cnt  = start_cnt + 1'b1;
		end
	end

	// Stop, SDA rises while SCL is high
	always @(posedge sda) begin
		if (scl === 1'b1 && in_frame) begin
			in_frame = 1'b0;
			fail_run = frame_nack ? fail_run + 1 : 0;
			stop_cnt = stop_cnt + 1'b1;
		end
	end

	// Data bits, MSB first
	always @(posedge scl) begin
		if (in_frame && !acking && bit_cnt < 4'd8) begin
			shreg   = {shreg[6:0], sda};
			bit_cnt = bit_cnt + 1'b1;
		end
	end

	always @(negedge scl) begin
		if (in_frame && acking) begin
			drive_low = 1'b0; // End of acknowledge clock
			acking    = 1'b0;
			bit_cnt   = '0;
			byte_idx  = byte_idx + 1'b1;
		end else if (in_frame && bit_cnt == 4'd8) begin
			roll    = $random(seed);
			// 1 in 8, but never enough in a row to exhaust the retries
			rx_nack = (roll[2:0] == 3'd0) && (fail_run < `I2C_MAX_RETRY - 1);
			if (force_mode && byte_idx == 2'd2 && {prev_byte, shreg} == cfg_table[force_idx])
				rx_nack = 1'b1;
			if (rx_nack)
				frame_nack = 1'b1;
			drive_low = !rx_nack;
			acking    = 1'b1;
			prev_byte = shreg;
			rx_byte   = shreg;
			byte_cnt  = byte_cnt + 1'b1; // Report after rx_byte is set
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_i2c_config.sv ====
// Testbench for the codec configuration block
// Random slave NACKs, then a forced failing entry, then a clean replay of the table
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_settings.svh"

module tb_i2c_config;

	localparam int TABLE_TIMEOUT = 20000; // Cycles for a whole table with retries

	logic        CLOCK;
	logic        RESET;
	logic        start;
	wire         i2c_sclk;
	wire         i2c_sdat;
	wire         config_done;
	wire         config_error;
	logic        force_mode;
	logic [3:0]  force_idx;
	logic [7:0]  rx_byte;
	logic        rx_nack;
	logic [15:0] byte_cnt;
	logic [15:0] start_cnt;
	logic [15:0] stop_cnt;
	int          errors;
	int          xfers;
	int          timeouts;
	bit          aborted;

	pullup (i2c_sdat);

	always begin
		CLOCK = 1'b0;
		#50;
		CLOCK = 1'b1;
		#50;
	end

	i2c_config_top i2c_config_top_inst (
		.CLOCK        (CLOCK),
		.RESET        (RESET),
		.start        (start),
		.i2c_sclk     (i2c_sclk),
		.i2c_sdat     (i2c_sdat),
		.config_done  (config_done),
		.config_error (config_error)
	);

	i2c_slave_model slave_inst (
		.scl        (i2c_sclk),
		.sda        (i2c_sdat),
		.force_mode (force_mode),
		.force_idx  (force_idx),
		.rx_byte    (rx_byte),
		.rx_nack    (rx_nack),
		.byte_cnt   (byte_cnt),
		.start_cnt  (start_cnt),
		.stop_cnt   (stop_cnt)
	);

	i2c_config_checker checker_inst (
		.CLOCK        (CLOCK),
		.RESET        (RESET),
		.start        (start),
		.scl          (i2c_sclk),
		.sda          (i2c_sdat),
		.config_done  (config_done),
		.config_error (config_error),
		.force_mode   (force_mode),
		.force_idx    (force_idx),
		.rx_byte      (rx_byte),
		.rx_nack      (rx_nack),
		.byte_cnt     (byte_cnt),
		.start_cnt    (start_cnt),
		.stop_cnt     (stop_cnt),
		.errors       (errors),
		.xfers        (xfers)
	);

	task automatic wait_done_level(input logic level, input int limit);
		int n;
		n = 0;
		while (config_done !== level && n < limit) begin
			@(posedge CLOCK);
			n = n + 1;
		end
		if (config_done !== level) begin
			$display("Timeout: config_done did not reach %b within %0d cycles", level, limit);
			timeouts = timeouts + 1;
			aborted  = 1'b1;
		end
	endtask

	// One-cycle start pulse
	task automatic pulse_start;
		@(posedge CLOCK);
		#10 start = 1'b1;
		@(posedge CLOCK);
		#10 start = 1'b0;
	endtask

	initial begin
		RESET      = 1'b0;
		start      = 1'b0;
		force_mode = 1'b0;
		force_idx  = 4'd4; // Interface format entry
		timeouts   = 0;
		aborted    = 1'b0;
		repeat (8) @(posedge CLOCK);
		#10 RESET = 1'b1;

		wait_done_level(1'b1, TABLE_TIMEOUT); // Runs by itself after reset
		if (!aborted) begin
			repeat (400) @(posedge CLOCK); // Bus must stay idle
			#10 force_mode = 1'b1;
			pulse_start();
			wait_done_level(1'b0, 8);
		end
		if (!aborted)
			wait_done_level(1'b1, TABLE_TIMEOUT);
		if (!aborted) begin
			repeat (400) @(posedge CLOCK);
			#10 force_mode = 1'b0; // Clean replay
			pulse_start();
			wait_done_level(1'b0, 8);
		end
		if (!aborted)
			wait_done_level(1'b1, TABLE_TIMEOUT);
		if (!aborted)
			repeat (400) @(posedge CLOCK);

		$display("%0d transfers checked, %0d errors, %0d timeouts", xfers, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/i2c_bit_clock.sv ====
// Bit-rate divider for the two-wire bus
// Splits each bit slot into four phases and strobes the first clock of every slot
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_settings.svh"

module i2c_bit_clock (
	input  logic                    CLOCK,
	input  logic                    RESET,
	output logic                    bit_tick,
	output i2c_cfg_pkg::scl_phase_t phase
);
	import i2c_cfg_pkg::*;

	localparam int DIV   = `I2C_CLK_DIV;
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] prescale;    // Clocks into the current quarter
	logic             quarter_end; // Last clock of a quarter

	assign quarter_end = (prescale == CNT_W'(DIV - 1));

	always_ff @(posedge CLOCK) begin
		if (!RESET) begin
			prescale <= '0;
			phase    <= PH_LOW0;
			bit_tick <= 1'b0;
		end else begin
			bit_tick <= 1'b0; // Single-clock strobe
			if (quarter_end) begin
				prescale <= '0;
				phase    <= scl_phase_t'(phase + 2'd1); // PH_FALL wraps to PH_LOW0
				bit_tick <= (phase == PH_FALL);         // Next slot begins
			end else begin
				prescale <= prescale + 1'b1;
			end
		end
	end

	// Strobe only on the first clock of PH_LOW0
	a_tick_phase: assert property (@(posedge CLOCK) disable iff (!RESET)
		bit_tick |-> (phase == PH_LOW0) && ($past(phase) == PH_FALL));

endmodule

`default_nettype wire

// ==== source/i2c_byte_controller.sv ====
// Two-wire byte controller
// Frames one 24-bit write word as start, three bytes with acknowledge slots and stop
// Any missing acknowledge is reported on ack_err
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_controller (
	input  logic                    CLOCK,
	input  logic                    RESET,
	input  logic                    bit_tick,
	input  i2c_cfg_pkg::scl_phase_t phase,
	i2c_xfer_if.slave               xfer,
	input  logic                    sda_in,
	output logic                    sda_out,
	output logic                    scl
);
	import i2c_cfg_pkg::*;

	localparam logic [5:0] SLOT_ACK1 = 6'd12; // Acknowledge after address byte
	localparam logic [5:0] SLOT_ACK2 = 6'd21; // After sub-address
	localparam logic [5:0] SLOT_ACK3 = 6'd30; // After data
	localparam logic [5:0] SLOT_LAST = 6'd63; // Counter saturates here

	logic [5:0] slot;      // Bit slot counter
	cfg_word_t  sd;        // Word held for the frame
	logic       sclk_r;    // SCL level outside the clocked window
	logic       done_r;
	logic       ack1;
	logic       ack2;
	logic       ack3;
	logic [1:0] sda_sync;  // Pad synchronizer
	logic       in_window; // Slots that carry an SCL pulse
	logic       scl_pulse; // High half of the bit

	assign xfer.done    = done_r;
	assign xfer.ack_err = ack1 | ack2 | ack3;

	// Slot counter, held at zero between transfers
	always_ff @(posedge CLOCK) begin
		if (!RESET) begin
			slot <= '0;
		end else if (!xfer.go) begin
			slot <= '0;
		end else if (bit_tick && slot != SLOT_LAST) begin
			slot <= slot + 6'd1;
		end
	end

	// Word capture at slot 1
	always_ff @(posedge CLOCK) begin
		if (xfer.go && bit_tick && slot == 6'd1)
			sd <= xfer.word;
	end

	// Framing, one action per bit strobe
	always_ff @(posedge CLOCK) begin
		if (!RESET) begin
			sclk_r  <= 1'b1;
			sda_out <= 1'b1; // Released
			done_r  <= 1'b1;
		end else if (xfer.go && bit_tick) begin
			case (slot) inside
				6'd0: begin
					done_r  <= 1'b0; // Busy from the first strobe
					sda_out <= 1'b1;
					sclk_r  <= 1'b1;
				end
				6'd1: sda_out <= 1'b0; // Start, SDA falls under high SCL
				6'd2: sclk_r <= 1'b0;
				[6'd3:6'd10]: sda_out <= sd.addr[3'(6'd10 - slot)]; // MSB first
				6'd11: sda_out <= 1'b1; // Release for ACK
				[6'd12:6'd19]: sda_out <= sd.sub[3'(6'd19 - slot)];
				6'd20: sda_out <= 1'b1;
				[6'd21:6'd28]: sda_out <= sd.data[3'(6'd28 - slot)];
				6'd29: sda_out <= 1'b1;
				6'd30: begin
					sda_out <= 1'b0; // Set up for stop
					sclk_r  <= 1'b0;
				end
				6'd31: sclk_r <= 1'b1;
				6'd32: begin
					sda_out <= 1'b1; // Stop, SDA rises under high SCL
					done_r  <= 1'b1;
				end
				default: ; // Saturated, bus idle
			endcase
		end
	end

	always_ff @(posedge CLOCK) begin
		if (!RESET)
			sda_sync <= 2'b11;
		else
			sda_sync <= {sda_sync[0], sda_in};
	end

	// Acknowledge sampling while SCL is high
	always_ff @(posedge CLOCK) begin
		if (!RESET) begin
			ack1 <= 1'b0;
			ack2 <= 1'b0;
			ack3 <= 1'b0;
		end else if (xfer.go && bit_tick && slot == 6'd0) begin
			ack1 <= 1'b0; // Previous result kept until now
			ack2 <= 1'b0;
			ack3 <= 1'b0;
		end else if (xfer.go && phase == PH_HIGH) begin
			if (slot == SLOT_ACK1)
				ack1 <= sda_sync[1]; // High means NACK
			if (slot == SLOT_ACK2)
				ack2 <= sda_sync[1];
			if (slot == SLOT_ACK3)
				ack3 <= sda_sync[1];
		end
	end

	assign in_window = (slot >= 6'd4) && (slot <= SLOT_ACK3);
	assign scl_pulse = (phase == PH_RISE) || (phase == PH_HIGH);

	// Registered so the pin never glitches
	always_ff @(posedge CLOCK) begin
		if (!RESET)
			scl <= 1'b1;
		else
			scl <= sclk_r | (in_window & scl_pulse);
	end

	// SDA only moves under high SCL for start and stop
	a_sda_stable: assert property (@(posedge CLOCK) disable iff (!RESET)
		(scl && $past(scl) && (sda_out != $past(sda_out)))
			|-> (slot == 6'd2 || slot == 6'd33));

	// Sequencer drops go only once the frame is over
	a_done_idle: assert property (@(posedge CLOCK) disable iff (!RESET)
		!xfer.go |-> xfer.done);

endmodule

`default_nettype wire

// ==== source/i2c_cfg_pkg.sv ====
// Codec configuration package
// Sequencer states, SCL quarter-bit phases, the write word and the register table
`default_nettype none
`include "i2c_cfg_settings.svh"

package i2c_cfg_pkg;

	typedef enum logic [2:0] {
		S_LOAD,  // Build word from the table
		S_ISSUE, // Raise go
		S_WAIT,  // Frame on the bus
		S_CHECK, // Retry, skip or advance
		S_DONE   // Table finished, bus idle
	} seq_state_t;

	typedef enum logic [1:0] {
		PH_LOW0 = 2'd0, // SCL low, SDA may move
		PH_RISE = 2'd1,
		PH_HIGH = 2'd2, // Acknowledge sample point
		PH_FALL = 2'd3
	} scl_phase_t;

	typedef struct packed {
		logic [7:0] addr; // Slave address, write bit
		logic [7:0] sub;  // Register sub-address
		logic [7:0] data; // Register value
	} cfg_word_t;

	// Sub-address/data pairs, 7-bit register number over a 9-bit value
	localparam logic [15:0] cfg_table [0:`I2C_TABLE_LEN-1] = '{
		16'h1E00, // Codec reset
		16'h0C00, // Power down control, all on
		16'h0812, // Analog path, DAC selected
		16'h0A06, // Digital path, de-emphasis
		16'h0E01, // Interface format, left justified
		16'h1002, // Sampling control
		16'h0017, // Left line in
		16'h0217, // Right line in
		16'h047B, // Left headphone volume
		16'h1201  // Interface active
	};

endpackage

`default_nettype wire

// ==== source/i2c_cfg_settings.svh ====
// Codec configuration settings
// Bus timing, codec address, retry limit and table size
`ifndef I2C_CFG_SETTINGS_SVH
`define I2C_CFG_SETTINGS_SVH

// System clocks per quarter bit
`define I2C_CLK_DIV 4

// Codec address byte with the write bit clear
`define I2C_SLAVE_ADDR 8'h34

// Attempts per table entry before it is skipped
`define I2C_MAX_RETRY 3

// Register writes in the table
`define I2C_TABLE_LEN 10

`endif

// ==== source/i2c_config_sequencer.sv ====
// Codec configuration sequencer
// Walks the register table, one write per entry, retrying entries that get a NACK
// A start pulse replays the whole table
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_settings.svh"

module i2c_config_sequencer (
	input  logic       CLOCK,
	input  logic       RESET,
	input  logic       start,
	i2c_xfer_if.master xfer,
	output logic       config_done,
	output logic       config_error
);
	import i2c_cfg_pkg::*;

	localparam int IDX_W = $clog2(`I2C_TABLE_LEN);
	localparam int TRY_W = $clog2(`I2C_MAX_RETRY + 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`I2C_TABLE_LEN - 1);

	seq_state_t       state;
	logic [IDX_W-1:0] idx;        // Entry in flight
	logic [TRY_W-1:0] tries;      // Failed attempts on this entry
	logic             seen_busy;  // Controller has dropped done
	logic             start_pend; // Start seen while a write was running
	logic             restart;
	logic             last_try;
	logic             go_r;
	cfg_word_t        word_r;

	assign xfer.go   = go_r;
	assign xfer.word = word_r;
	assign restart   = start | start_pend;
	assign last_try  = (tries == TRY_W'(`I2C_MAX_RETRY - 1));

	// Write word, rebuilt only when an entry is loaded
	always_ff @(posedge CLOCK) begin
		if (state == S_LOAD) begin
			word_r.addr <= `I2C_SLAVE_ADDR;
			word_r.sub  <= cfg_table[idx][15:8];
			word_r.data <= cfg_table[idx][7:0];
		end
	end

	always_ff @(posedge CLOCK) begin
		if (!RESET) begin
			state        <= S_LOAD; // Runs straight after reset
			idx          <= '0;
			tries        <= '0;
			seen_busy    <= 1'b0;
			start_pend   <= 1'b0;
			go_r         <= 1'b0;
			config_done  <= 1'b0;
			config_error <= 1'b0;
		end else begin
			if (start) begin
				config_done  <= 1'b0; // Status cleared at once
				config_error <= 1'b0;
				start_pend   <= 1'b1;
			end
			case (state)
				S_LOAD: begin
					tries <= '0;
					state <= S_ISSUE;
				end
				S_ISSUE: begin
					go_r      <= 1'b1;
					seen_busy <= 1'b0;
					state     <= S_WAIT;
				end
				S_WAIT: begin
					if (!xfer.done) begin
						seen_busy <= 1'b1;
					end else if (seen_busy) begin
						go_r  <= 1'b0; // Frame finished
						state <= S_CHECK;
					end
				end
				S_CHECK: begin
					if (restart) begin
						idx        <= '0; // Replay from entry 0
						start_pend <= 1'b0;
						state      <= S_LOAD;
					end else if (xfer.ack_err && !last_try) begin
						tries <= tries + 1'b1;
						state <= S_ISSUE; // Same word again
					end else begin
						if (xfer.ack_err)
							config_error <= 1'b1; // Sticky, entry skipped
						if (idx == LAST_IDX) begin
							config_done <= 1'b1;
							state       <= S_DONE;
						end else begin
							idx   <= idx + 1'b1;
							state <= S_LOAD;
						end
					end
				end
				S_DONE: begin
					if (restart) begin
						idx        <= '0;
						start_pend <= 1'b0;
						state      <= S_LOAD;
					end
				end
				default: state <= S_LOAD;
			endcase
		end
	end

	// Finished table leaves the controller idle
	a_idle_done: assert property (@(posedge CLOCK) disable iff (!RESET)
		(state == S_DONE) |-> (!xfer.go && xfer.done));

endmodule

`default_nettype wire

// ==== source/i2c_config_top.sv ====
// Codec configuration block on the two-wire bus
// Divider, table sequencer and byte controller with the open-drain SDA pad
`timescale 1ns/1ps
`default_nettype none

module i2c_config_top (
	input  logic CLOCK,
	input  logic RESET,
	input  logic start,        // Replays the table
	output logic i2c_sclk,
	inout  wire  i2c_sdat,     // Needs an external pull-up
	output logic config_done,
	output logic config_error  // Some entry never acknowledged
);
	import i2c_cfg_pkg::*;

	logic       bit_tick;
	scl_phase_t phase;
	logic       sda_out; // Zero pulls the pad low
	logic       sda_in;

	i2c_xfer_if xfer ();

	i2c_bit_clock bit_clock_inst (
		.CLOCK    (CLOCK),
		.RESET    (RESET),
		.bit_tick (bit_tick),
		.phase    (phase)
	);

	i2c_config_sequencer sequencer_inst (
		.CLOCK        (CLOCK),
		.RESET        (RESET),
		.start        (start),
		.xfer         (xfer),
		.config_done  (config_done),
		.config_error (config_error)
	);

	i2c_byte_controller controller_inst (
		.CLOCK    (CLOCK),
		.RESET    (RESET),
		.bit_tick (bit_tick),
		.phase    (phase),
		.xfer     (xfer),
		.sda_in   (sda_in),
		.sda_out  (sda_out),
		.scl      (i2c_sclk)
	);

	// Open drain, low or released
	assign i2c_sdat = sda_out ? 1'bz : 1'b0;
	assign sda_in   = i2c_sdat; // Slave ACK read back

endmodule

`default_nettype wire

// ==== source/i2c_xfer_if.sv ====
// Transfer request channel between the sequencer and the byte controller
// One 24-bit write word with go, done and acknowledge-error levels
`timescale 1ns/1ps
`default_nettype none

interface i2c_xfer_if;
	import i2c_cfg_pkg::*;

	cfg_word_t word;    // Address, sub-address, data
	logic      go;      // Held high for one whole transfer
	logic      done;    // Low while a frame is on the bus
	logic      ack_err; // Any NACK in the last frame

	// Sequencer side
	modport master (
		output word,
		output go,
		input  done,
		input  ack_err
	);

	// Byte controller side
	modport slave (
		input  word,
		input  go,
		output done,
		output ack_err
	);

endinterface

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/i2c_cfg_pkg.sv
source/i2c_xfer_if.sv
source/i2c_bit_clock.sv
source/i2c_byte_controller.sv
source/i2c_config_sequencer.sv
source/i2c_config_top.sv
sim/i2c_slave_model.sv
sim/i2c_config_checker.sv
sim/tb_i2c_config.sv
